// ==== project.f ====
hdl/dbg_unit_pkg.sv
hdl/dbg_reg_if.sv
hdl/dbg_host_port.sv
hdl/dbg_regs.sv
hdl/dbg_breakpoint.sv
hdl/dbg_cpu_ctrl.sv
hdl/dbg_unit.sv
testbench/tb_clock_gen.sv
testbench/tb_dbg_unit.sv

// ==== Bender.yml ====
package:
  name: dbg_unit

sources:
  - files:
      - hdl/dbg_unit_pkg.sv
      - hdl/dbg_reg_if.sv
      - hdl/dbg_host_port.sv
      - hdl/dbg_regs.sv
      - hdl/dbg_breakpoint.sv
      - hdl/dbg_cpu_ctrl.sv
      - hdl/dbg_unit.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_dbg_unit.sv

// ==== testbench/tb_dbg_unit.sv ====
// Table-driven testbench for the debug unit; host accesses, CPU events and output probes
`timescale 1ns/10ps
`default_nettype none

module tb_dbg_unit;
  import dbg_unit_pkg::*;

  typedef enum logic [1:0] {OP_RD, OP_WR, OP_CPU, OP_CHK} op_e;
  typedef enum logic [2:0] {EV_NONE, EV_FETCH, EV_FETCH_FLUSH, EV_STEP, EV_LOAD, EV_STORE,
                            EV_EXC} ev_e;
  typedef struct packed {
    op_e         op;
    ev_e         kind;
    logic        stall;
    logic [15:0] addr;
    logic [31:0] data;
    logic [31:0] expv;
  } row_t;

  localparam int unsigned SEED     = 32'hd9b1504d;
  localparam int          ACK_WAIT = 8;
  // Probe selects for OP_CHK rows
  localparam logic [15:0] PRB_IE      = 0;
  localparam logic [15:0] PRB_RF_WE   = 1;
  localparam logic [15:0] PRB_RF_ADDR = 2;
  localparam logic [15:0] PRB_RF_D    = 3;
  localparam logic [15:0] PRB_LATCH   = 4;
  localparam logic [15:0] PRB_FLUSH   = 5;
  localparam logic [15:0] PRB_CSR_WE  = 6;
  localparam logic [15:0] PRB_PC_WE   = 7;
  localparam logic [15:0] PRB_RD_STRB = 8;
  localparam logic [15:0] PRB_STALL   = 9;

  logic clk, rst_n;
  logic dbg_stall, dbg_strb, dbg_we, dbg_ack, dbg_bp;
  logic [15:0] dbg_addr;
  logic [31:0] dbg_d, dbg_q, du_d, du_ie, rf_q, csr_q, nxt_pc, pd_pc, mem_adr, exceptions;
  logic du_stall, du_stall_if, du_latch, du_flush, du_we_rf, du_re_rf, du_we_csr, du_re_csr;
  logic du_we_pc, pd_valid, if_nxt_valid, flush, mem_read, mem_write, dmem_ack;
  logic [11:0] du_addr;

  row_t        rows[$];
  string       names[$];
  logic        cur_stall;
  int          checks, val_errs, proto_errs, cycles, cycle_limit;
  int          rf_we_cnt, latch_cnt, flush_cnt, csr_we_cnt, pc_we_cnt;
  logic [11:0] rf_addr_seen;
  logic [1:0]  rd_strb_seen;
  logic [31:0] rf_d_seen, pc_val, mem_val, ie_val, gpr_val;

  tb_clock_gen u_clock_gen (.clk_o(clk), .rst_no(rst_n));

  dbg_unit dut (
    .clk_i(clk), .rst_ni(rst_n), .dbg_stall_i(dbg_stall), .dbg_strb_i(dbg_strb),
    .dbg_we_i(dbg_we), .dbg_addr_i(dbg_addr), .dbg_d_i(dbg_d), .dbg_q_o(dbg_q),
    .dbg_ack_o(dbg_ack), .dbg_bp_o(dbg_bp), .du_stall_o(du_stall), .du_stall_if_o(du_stall_if),
    .du_latch_nxt_pc_o(du_latch), .du_flush_o(du_flush), .du_we_rf_o(du_we_rf),
    .du_re_rf_o(du_re_rf), .du_we_csr_o(du_we_csr), .du_re_csr_o(du_re_csr),
    .du_we_pc_o(du_we_pc), .du_addr_o(du_addr), .du_d_o(du_d), .du_ie_o(du_ie),
    .du_rf_q_i(rf_q), .st_csr_q_i(csr_q), .if_nxt_pc_i(nxt_pc), .pd_pc_i(pd_pc),
    .pd_valid_i(pd_valid), .if_nxt_valid_i(if_nxt_valid), .flush_i(flush),
    .mem_memadr_i(mem_adr), .mem_read_i(mem_read), .mem_write_i(mem_write),
    .dmem_ack_i(dmem_ack), .du_exceptions_i(exceptions)
  );

  //////////////////////////////////////////////////////////////////////
  // Table building
  task automatic push_row(input string name, input op_e op, input ev_e kind,
                          input logic [15:0] addr, input logic [31:0] data,
                          input logic [31:0] expv);
    rows.push_back('{op: op, kind: kind, stall: cur_stall, addr: addr, data: data, expv: expv});
    names.push_back(name);
  endtask

  task automatic add_rd(input string name, input logic [15:0] addr, input logic [31:0] expv);
    push_row(name, OP_RD, EV_NONE, addr, '0, expv);
  endtask

  task automatic add_wr(input string name, input logic [15:0] addr, input logic [31:0] data);
    push_row(name, OP_WR, EV_NONE, addr, data, '0);
  endtask

  // Stall level set here holds for the rows that follow
  task automatic add_cpu(input string name, input logic stall, input ev_e kind,
                         input logic [31:0] value, input logic bp_exp);
    cur_stall = stall;
    push_row(name, OP_CPU, kind, '0, value, {31'b0, bp_exp});
  endtask

  task automatic add_chk(input string name, input logic [15:0] sel, input logic [31:0] expv);
    push_row(name, OP_CHK, EV_NONE, sel, '0, expv);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Row application
  task automatic check_value(input string name, input logic [31:0] expv, input logic [31:0] got);
    checks++;
    assert (got === expv)
    else
    begin
      $display("ERR %s: expected %h, actual %h", name, expv, got);
      val_errs++;
    end
  endtask

  task automatic host_access(input row_t r, input string name, output logic [31:0] q,
                             output bit acked);
    int waited;
    @(posedge clk);
    dbg_stall <= r.stall;
    dbg_strb  <= 1'b1;
    dbg_we    <= r.op == OP_WR;
    dbg_addr  <= r.addr;
    dbg_d     <= r.data;
    acked  = 1'b0;
    waited = 0;
    q      = '0;
    while (!acked && waited < ACK_WAIT)
    begin
      @(negedge clk);
      if (dbg_ack)
      begin
        acked        = 1'b1;
        q            = dbg_q;
        rd_strb_seen = {du_re_csr, du_re_rf};
      end
      waited++;
    end
    assert (acked)
    else
    begin
      $display("No acknowledge from the debug unit for %s within %0d cycles", name, ACK_WAIT);
      proto_errs++;
    end
    @(posedge clk);
    dbg_strb <= 1'b0;
    dbg_we   <= 1'b0;
  endtask

  // One cycle of CPU stimulus; exceptions show on dbg_bp a cycle before hits do
  task automatic cpu_event(input row_t r, output logic bp_seen);
    @(posedge clk);
    dbg_stall <= r.stall;
    case (r.kind)
      EV_FETCH:
      begin
        pd_pc    <= r.data;
        pd_valid <= 1'b1;
      end
      EV_FETCH_FLUSH:
      begin
        pd_pc    <= r.data;
        pd_valid <= 1'b1;
        flush    <= 1'b1;
      end
      EV_STEP:
        if_nxt_valid <= 1'b1;
      EV_LOAD:
      begin
        mem_adr  <= r.data;
        mem_read <= 1'b1;
        dmem_ack <= 1'b1;
      end
      EV_STORE:
      begin
        mem_adr   <= r.data;
        mem_write <= 1'b1;
        dmem_ack  <= 1'b1;
      end
      EV_EXC:
        exceptions <= r.data;
      default:
        ;
    endcase
    @(posedge clk);
    pd_valid     <= 1'b0;
    flush        <= 1'b0;
    if_nxt_valid <= 1'b0;
    mem_read     <= 1'b0;
    mem_write    <= 1'b0;
    dmem_ack     <= 1'b0;
    exceptions   <= '0;
    @(negedge clk);
    bp_seen = dbg_bp;
    @(negedge clk);
    bp_seen = bp_seen | dbg_bp;
  endtask

  function automatic logic [31:0] probe_value(input logic [15:0] sel);
    case (sel)
      PRB_IE:      return du_ie;
      PRB_RF_WE:   return rf_we_cnt;
      PRB_RF_ADDR: return {20'b0, rf_addr_seen};
      PRB_RF_D:    return rf_d_seen;
      PRB_LATCH:   return latch_cnt;
      PRB_FLUSH:   return flush_cnt;
      PRB_CSR_WE:  return csr_we_cnt;
      PRB_PC_WE:   return pc_we_cnt;
      PRB_RD_STRB: return {30'b0, rd_strb_seen};
      PRB_STALL:   return {30'b0, du_stall_if, du_stall};
      default:     return 'x;
    endcase
  endfunction

  // Pulse counters toward the CPU
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (du_we_rf)
      begin
        rf_we_cnt++;
        rf_addr_seen = du_addr;
        rf_d_seen    = du_d;
      end
      if (du_we_csr)
        csr_we_cnt++;
      if (du_we_pc)
        pc_we_cnt++;
      if (du_latch)
        latch_cnt++;
      if (du_flush)
        flush_cnt++;
    end
  end

  initial
  begin
    wait (rst_n === 1'b1);
    while (cycles <= cycle_limit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Run stopped after %0d cycles without finishing the table", cycle_limit);
    $display("Test failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  initial
  begin
    row_t        r;
    logic [31:0] got;
    bit          acked;
    logic        bp_seen;
    {dbg_stall, dbg_strb, dbg_we, dbg_addr, dbg_d} = '0;
    {pd_pc, pd_valid, if_nxt_valid, flush, mem_adr, mem_read, mem_write, dmem_ack} = '0;
    exceptions = '0;
    {checks, val_errs, proto_errs, cycles, rf_we_cnt, latch_cnt, flush_cnt} = '0;
    {csr_we_cnt, pc_we_cnt} = '0;
    {rf_addr_seen, rf_d_seen, rd_strb_seen} = '0;
    cycle_limit = 1000;
    cur_stall   = 1'b0;
    void'($urandom(SEED));
    pc_val  = $urandom;
    mem_val = $urandom;
    ie_val  = $urandom;
    gpr_val = $urandom;
    rf_q    = $urandom;
    csr_q   = $urandom;
    nxt_pc  = $urandom;

    add_rd("reset_ctrl", {BANK_INTERNAL, REG_CTRL}, 0);
    add_rd("reset_hit", {BANK_INTERNAL, REG_HIT}, 0);
    add_rd("reset_ie", {BANK_INTERNAL, REG_IE}, 0);
    add_rd("reset_cause", {BANK_INTERNAL, REG_CAUSE}, 0);
    for (int n = 0; n < NUM_BP; n++)
      add_rd($sformatf("reset_bpctrl%0d", n), {BANK_INTERNAL, REG_BPCTRL0 + 12'(2 * n)}, 1);
    add_cpu("reset_bp_low", 1'b0, EV_NONE, 0, 1'b0);
    add_wr("ie_write", {BANK_INTERNAL, REG_IE}, ie_val);
    add_rd("ie_read", {BANK_INTERNAL, REG_IE}, ie_val);
    add_chk("ie_output", PRB_IE, ie_val);
    add_wr("bpctrl0_all_ones", {BANK_INTERNAL, REG_BPCTRL0}, 32'hffff_ffff);
    add_rd("bpctrl0_mask", {BANK_INTERNAL, REG_BPCTRL0}, 32'h73);
    add_wr("bpdata0_write", {BANK_INTERNAL, REG_BPDATA0}, pc_val);
    add_rd("bpdata0_read", {BANK_INTERNAL, REG_BPDATA0}, pc_val);
    add_wr("bp0_fetch_on", {BANK_INTERNAL, REG_BPCTRL0}, {CC_FETCH, 4'b0010});
    add_cpu("fetch_mismatch", 1'b0, EV_FETCH, pc_val ^ 32'h4, 1'b0);
    add_cpu("fetch_flushed", 1'b0, EV_FETCH_FLUSH, pc_val, 1'b0);
    add_rd("hit_still_clear", {BANK_INTERNAL, REG_HIT}, 0);
    add_cpu("fetch_match", 1'b0, EV_FETCH, pc_val, 1'b1);
    add_rd("hit_fetch", {BANK_INTERNAL, REG_HIT}, 32'h10);
    // Pending hit holds fetch, stall input low
    add_chk("stall_if_on_hit", PRB_STALL, 32'h2);
    add_wr("hit_clear", {BANK_INTERNAL, REG_HIT}, 0);
    add_rd("hit_cleared", {BANK_INTERNAL, REG_HIT}, 0);
    add_chk("stall_if_idle", PRB_STALL, 0);
    add_wr("step_on", {BANK_INTERNAL, REG_CTRL}, 1);
    add_rd("ctrl_read", {BANK_INTERNAL, REG_CTRL}, 1);
    add_cpu("step_instr", 1'b0, EV_STEP, 0, 1'b1);
    add_rd("hit_step", {BANK_INTERNAL, REG_HIT}, 1);
    add_wr("step_off", {BANK_INTERNAL, REG_CTRL}, 0);
    add_wr("hit_clear_step", {BANK_INTERNAL, REG_HIT}, 0);
    add_wr("bpdata1_write", {BANK_INTERNAL, REG_BPDATA0 + 12'd2}, mem_val);
    add_wr("bpdata2_write", {BANK_INTERNAL, REG_BPDATA0 + 12'd4}, mem_val);
    add_wr("bp1_load_on", {BANK_INTERNAL, REG_BPCTRL0 + 12'd2}, {CC_LOAD, 4'b0010});
    add_wr("bp2_store_on", {BANK_INTERNAL, REG_BPCTRL0 + 12'd4}, {CC_STORE, 4'b0010});
    add_cpu("load_match", 1'b0, EV_LOAD, mem_val, 1'b1);
    add_rd("hit_load", {BANK_INTERNAL, REG_HIT}, 32'h20);
    add_wr("hit_clear_load", {BANK_INTERNAL, REG_HIT}, 0);
    add_cpu("store_match", 1'b0, EV_STORE, mem_val, 1'b1);
    add_rd("hit_store", {BANK_INTERNAL, REG_HIT}, 32'h40);
    add_wr("hit_clear_store", {BANK_INTERNAL, REG_HIT}, 0);
    add_cpu("trap_5_9", 1'b0, EV_EXC, 32'h0000_0220, 1'b1);
    add_rd("cause_trap", {BANK_INTERNAL, REG_CAUSE}, 5);
    add_cpu("irq_18", 1'b0, EV_EXC, 32'h0004_0000, 1'b1);
    add_rd("cause_irq", {BANK_INTERNAL, REG_CAUSE}, 32'h8000_0002);
    add_cpu("stall_rise", 1'b1, EV_NONE, 0, 1'b0);
    add_chk("latch_pulse", PRB_LATCH, 1);
    add_chk("stall_out", PRB_STALL, 32'h3);
    add_wr("gpr_write", {BANK_GPRS, 12'h005}, gpr_val);
    add_chk("gpr_we_pulse", PRB_RF_WE, 1);
    add_chk("gpr_we_addr", PRB_RF_ADDR, 32'h005);
    add_chk("gpr_we_data", PRB_RF_D, gpr_val);
    add_wr("csr_write", {BANK_CSRS, 12'h300}, gpr_val);
    add_chk("csr_we_pulse", PRB_CSR_WE, 1);
    add_wr("npc_write", {BANK_GPRS, NPC_OFFSET}, pc_val);
    add_chk("npc_we_pulse", PRB_PC_WE, 1);
    add_chk("gpr_we_once", PRB_RF_WE, 1);
    add_rd("gpr_read", {BANK_GPRS, 12'h007}, rf_q);
    add_chk("gpr_re_strobe", PRB_RD_STRB, 32'h1);
    add_rd("csr_read", {BANK_CSRS, 12'h300}, csr_q);
    add_chk("csr_re_strobe", PRB_RD_STRB, 32'h2);
    add_rd("npc_read", {BANK_GPRS, NPC_OFFSET}, nxt_pc);
    add_cpu("stall_fall", 1'b0, EV_NONE, 0, 1'b0);
    add_chk("flush_pulse", PRB_FLUSH, 1);
    add_rd("cause_cleared", {BANK_INTERNAL, REG_CAUSE}, 0);
    add_chk("latch_once", PRB_LATCH, 1);
    cycle_limit = rows.size() * 8 + 100;

    wait (rst_n === 1'b1);
    for (int i = 0; i < rows.size(); i++)
    begin
      r = rows[i];
      case (r.op)
        OP_RD, OP_WR:
        begin
          host_access(r, names[i], got, acked);
          if (acked && r.op == OP_RD)
            check_value(names[i], r.expv, got);
        end
        OP_CPU:
        begin
          cpu_event(r, bp_seen);
          check_value(names[i], r.expv, {31'b0, bp_seen});
        end
        default:
        begin
          @(negedge clk);
          check_value(names[i], r.expv, probe_value(r.addr));
        end
      endcase
    end

    $display("Checks: %0d, value errors: %0d, protocol errors: %0d",
             checks, val_errs, proto_errs);
    if (val_errs == 0 && proto_errs == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
// Testbench clock (8 ns period) and active-low reset held for the first three cycles
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam time HALF_PERIOD = 4ns;

  initial
  begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Release away from the active edge
  initial
  begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// ==== hdl/dbg_unit.sv ====
// Debug unit top level; connects host port, registers, breakpoints and CPU control
`timescale 1ns/10ps
`default_nettype none

module dbg_unit (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  // Host port
  input  logic                                dbg_stall_i,
  input  logic                                dbg_strb_i,
  input  logic                                dbg_we_i,
  input  logic [dbg_unit_pkg::DBG_ADDR_W-1:0] dbg_addr_i,
  input  logic [dbg_unit_pkg::XLEN-1:0]       dbg_d_i,
  output logic [dbg_unit_pkg::XLEN-1:0]       dbg_q_o,
  output logic                                dbg_ack_o,
  output logic                                dbg_bp_o,

  // CPU side
  output logic                                du_stall_o,
  output logic                                du_stall_if_o,
  output logic                                du_latch_nxt_pc_o,
  output logic                                du_flush_o,
  output logic                                du_we_rf_o,
  output logic                                du_re_rf_o,
  output logic                                du_we_csr_o,
  output logic                                du_re_csr_o,
  output logic                                du_we_pc_o,
  output logic [dbg_unit_pkg::DU_ADDR_W-1:0]  du_addr_o,
  output logic [dbg_unit_pkg::XLEN-1:0]       du_d_o,
  output logic [31:0]                         du_ie_o,
  input  logic [dbg_unit_pkg::XLEN-1:0]       du_rf_q_i,
  input  logic [dbg_unit_pkg::XLEN-1:0]       st_csr_q_i,
  input  logic [dbg_unit_pkg::XLEN-1:0]       if_nxt_pc_i,
  input  logic [dbg_unit_pkg::XLEN-1:0]       pd_pc_i,
  input  logic                                pd_valid_i,
  input  logic                                if_nxt_valid_i,
  input  logic                                flush_i,
  input  logic [dbg_unit_pkg::XLEN-1:0]       mem_memadr_i,
  input  logic                                mem_read_i,
  input  logic                                mem_write_i,
  input  logic                                dmem_ack_i,
  input  logic [31:0]                         du_exceptions_i
);
  import dbg_unit_pkg::*;

  logic [NUM_BP-1:0]           bp_hit;
  logic [NUM_BP-1:0][XLEN-1:0] bp_rdata;
  logic                        hit_any;

  dbg_reg_if regs_bus ();

  //////////////////////////////////////////////////////////////////////
  // Host side
  dbg_host_port u_host_port (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .dbg_strb_i  (dbg_strb_i),
    .dbg_we_i    (dbg_we_i),
    .dbg_addr_i  (dbg_addr_i),
    .dbg_d_i     (dbg_d_i),
    .dbg_stall_i (dbg_stall_i),
    .rf_q_i      (du_rf_q_i),
    .csr_q_i     (st_csr_q_i),
    .nxt_pc_i    (if_nxt_pc_i),
    .dbg_q_o     (dbg_q_o),
    .dbg_ack_o   (dbg_ack_o),
    .we_rf_o     (du_we_rf_o),
    .re_rf_o     (du_re_rf_o),
    .we_csr_o    (du_we_csr_o),
    .re_csr_o    (du_re_csr_o),
    .we_pc_o     (du_we_pc_o),
    .cpu_addr_o  (du_addr_o),
    .cpu_d_o     (du_d_o),
    .regs_o      (regs_bus)
  );

  dbg_regs u_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .regs_i       (regs_bus),
    .step_valid_i (if_nxt_valid_i),
    .exceptions_i (du_exceptions_i),
    .flush_exit_i (du_flush_o),
    .bp_hit_i     (bp_hit),
    .bp_rdata_i   (bp_rdata),
    .ie_o         (du_ie_o),
    .hit_any_o    (hit_any)
  );

  //////////////////////////////////////////////////////////////////////
  // Breakpoints
  for (genvar n = 0; n < NUM_BP; n++)
  begin : gen_bp
    dbg_breakpoint #(
      .BP_INDEX (n)
    ) u_bp (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .regs_i        (regs_bus),
      .fetch_pc_i    (pd_pc_i),
      .fetch_valid_i (pd_valid_i),
      .flush_i       (flush_i),
      .mem_addr_i    (mem_memadr_i),
      .mem_read_i    (mem_read_i),
      .mem_write_i   (mem_write_i),
      .dmem_ack_i    (dmem_ack_i),
      .hit_o         (bp_hit[n]),
      .rdata_o       (bp_rdata[n])
    );
  end

  dbg_cpu_ctrl u_cpu_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .dbg_stall_i    (dbg_stall_i),
    .flush_i        (flush_i),
    .exceptions_i   (du_exceptions_i),
    .hit_any_i      (hit_any),
    .latch_nxt_pc_o (du_latch_nxt_pc_o),
    .flush_o        (du_flush_o),
    .dbg_bp_o       (dbg_bp_o)
  );

  // Fetch also halts on any pending hit
  assign du_stall_o    = dbg_stall_i;
  assign du_stall_if_o = dbg_stall_i | hit_any;

endmodule

`default_nettype wire

// ==== hdl/dbg_cpu_ctrl.sv ====
// Stall entry and exit pulses toward the CPU and the registered breakpoint flag to the host
`timescale 1ns/10ps
`default_nettype none

module dbg_cpu_ctrl (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        dbg_stall_i,
  input  logic        flush_i,
  input  logic [31:0] exceptions_i,
  input  logic        hit_any_i,
  output logic        latch_nxt_pc_o,
  output logic        flush_o,
  output logic        dbg_bp_o
);

  logic stall_q;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      stall_q        <= 1'b0;
      latch_nxt_pc_o <= 1'b0;
      flush_o        <= 1'b0;
      dbg_bp_o       <= 1'b0;
    end
    else
    begin
      stall_q        <= dbg_stall_i;
      // Entering debug, capture next PC
      latch_nxt_pc_o <= dbg_stall_i & ~stall_q;
      // Leaving debug, memory may have changed
      flush_o        <= ~dbg_stall_i & stall_q;
      // No break reported while the pipeline is flushed
      dbg_bp_o       <= ~flush_o & ~flush_i & ((|exceptions_i) | hit_any_i);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/dbg_breakpoint.sv ====
// One address breakpoint with its control and data registers and hit comparator
`timescale 1ns/10ps
`default_nettype none

module dbg_breakpoint #(
  parameter int unsigned BP_INDEX = 0
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  dbg_reg_if.bp                         regs_i,
  input  logic [dbg_unit_pkg::XLEN-1:0] fetch_pc_i,
  input  logic                          fetch_valid_i,
  input  logic                          flush_i,
  input  logic [dbg_unit_pkg::XLEN-1:0] mem_addr_i,
  input  logic                          mem_read_i,
  input  logic                          mem_write_i,
  input  logic                          dmem_ack_i,
  output logic                          hit_o,
  output logic [dbg_unit_pkg::XLEN-1:0] rdata_o
);
  import dbg_unit_pkg::*;

  logic            sel_ctrl;
  logic            sel_data;
  logic [CC_W-1:0] cc_q;
  logic            en_q;
  logic [XLEN-1:0] data_q;
  bp_ctrl_t        ctrl;
  logic            pc_match;
  logic            mem_match;

  // Own register pair
  assign sel_ctrl = regs_i.addr == DU_ADDR_W'(REG_BPCTRL0 + 2 * BP_INDEX);
  assign sel_data = regs_i.addr == DU_ADDR_W'(REG_BPDATA0 + 2 * BP_INDEX);

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      cc_q   <= '0;
      en_q   <= 1'b0;
      data_q <= '0;
    end
    else if (regs_i.we)
    begin
      if (sel_ctrl)
      begin
        cc_q <= regs_i.wdata[6:4];
        en_q <= regs_i.wdata[1];
      end
      if (sel_data)
        data_q <= regs_i.wdata;
    end
  end

  assign ctrl = '{cc: cc_q, enabled: en_q, implemented: 1'b1};

  always_comb
  begin
    if (sel_ctrl)
      rdata_o = {{(XLEN-7){1'b0}}, ctrl.cc, 2'b00, ctrl.enabled, ctrl.implemented};
    else if (sel_data)
      rdata_o = data_q;
    else
      rdata_o = '0;
  end

  //////////////////////////////////////////////////////////////////////
  // Hit comparator
  assign pc_match  = fetch_pc_i == data_q;
  assign mem_match = (mem_addr_i == data_q) & dmem_ack_i;

  always_comb
  begin
    if (!ctrl.enabled)
      hit_o = 1'b0;
    else
      case (ctrl.cc)
        CC_FETCH: hit_o = pc_match & fetch_valid_i & ~flush_i;
        CC_LOAD:  hit_o = mem_match & mem_read_i;
        CC_STORE: hit_o = mem_match & mem_write_i;
        CC_LDST:  hit_o = mem_match & (mem_read_i | mem_write_i);
        default:  hit_o = 1'b0;
      endcase
  end

endmodule

`default_nettype wire

// ==== hdl/dbg_regs.sv ====
// Debug control, hit, interrupt-enable and cause registers with the internal read mux
`timescale 1ns/10ps
`default_nettype none

module dbg_regs (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  dbg_reg_if.regs                                        regs_i,
  input  logic                                           step_valid_i,
  input  logic [31:0]                                    exceptions_i,
  input  logic                                           flush_exit_i,
  input  logic [dbg_unit_pkg::NUM_BP-1:0]                bp_hit_i,
  input  logic [dbg_unit_pkg::NUM_BP-1:0][dbg_unit_pkg::XLEN-1:0] bp_rdata_i,
  output logic [31:0]                                    ie_o,
  output logic                                           hit_any_o
);
  import dbg_unit_pkg::*;

  logic              step_en_q;
  logic              step_hit_q;
  logic [NUM_BP-1:0] bp_hit_q;
  logic [31:0]       ie_q;
  logic [XLEN-1:0]   cause_q;
  logic [4:0]        trap_idx;
  logic [4:0]        irq_idx;
  logic [XLEN-1:0]   hit_word;
  logic [XLEN-1:0]   int_word;

  //////////////////////////////////////////////////////////////////////
  // CTRL and IE
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      step_en_q <= 1'b0;
      ie_q      <= '0;
    end
    else if (regs_i.we)
    begin
      if (regs_i.addr == REG_CTRL)
        step_en_q <= regs_i.wdata[0];
      if (regs_i.addr == REG_IE)
        ie_q <= regs_i.wdata[31:0];
    end
  end

  assign ie_o = ie_q;

  // HIT flags are sticky until the host rewrites them
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      step_hit_q <= 1'b0;
      bp_hit_q   <= '0;
    end
    else if (regs_i.we && regs_i.addr == REG_HIT)
    begin
      step_hit_q <= regs_i.wdata[0];
      bp_hit_q   <= regs_i.wdata[HIT_BP_LSB +: NUM_BP];
    end
    else
    begin
      if (step_en_q && step_valid_i)
        step_hit_q <= 1'b1;
      bp_hit_q <= bp_hit_q | bp_hit_i;
    end
  end

  assign hit_any_o = step_hit_q | (|bp_hit_q);

  //////////////////////////////////////////////////////////////////////
  // CAUSE encoding, lowest set bit wins
  always_comb
  begin
    trap_idx = '0;
    irq_idx  = '0;
    for (int i = IRQ_BASE - 1; i >= 0; i--)
      if (exceptions_i[i])
        trap_idx = 5'(i);
    for (int i = 31; i >= IRQ_BASE; i--)
      if (exceptions_i[i])
        irq_idx = 5'(i - IRQ_BASE);
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      cause_q <= '0;
    else if (regs_i.we && regs_i.addr == REG_CAUSE)
      cause_q <= regs_i.wdata;
    else if (flush_exit_i && !(|exceptions_i))
      cause_q <= '0;
    else if (|exceptions_i[IRQ_BASE-1:0])
      cause_q <= XLEN'(trap_idx);
    else if (|exceptions_i[31:IRQ_BASE])
      // Interrupts carry the top bit
      cause_q <= {1'b1, {(XLEN-6){1'b0}}, irq_idx};
  end

  //////////////////////////////////////////////////////////////////////
  // Read mux
  always_comb
  begin
    hit_word                         = '0;
    hit_word[0]                      = step_hit_q;
    hit_word[HIT_BP_LSB +: NUM_BP]   = bp_hit_q;
  end

  always_comb
  begin
    case (regs_i.addr)
      REG_CTRL:  int_word = {{(XLEN-1){1'b0}}, step_en_q};
      REG_HIT:   int_word = hit_word;
      REG_IE:    int_word = ie_q;
      REG_CAUSE: int_word = cause_q;
      default:   int_word = '0;
    endcase
    // Breakpoint words are zero unless addressed
    for (int n = 0; n < NUM_BP; n++)
      int_word = int_word | bp_rdata_i[n];
  end

  assign regs_i.rdata = int_word;

endmodule

`default_nettype wire

// ==== hdl/dbg_host_port.sv ====
// Host strobe/acknowledge port; decodes banks, times the ack and drives CPU and internal strobes
`timescale 1ns/10ps
`default_nettype none

module dbg_host_port (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                dbg_strb_i,
  input  logic                                dbg_we_i,
  input  logic [dbg_unit_pkg::DBG_ADDR_W-1:0] dbg_addr_i,
  input  logic [dbg_unit_pkg::XLEN-1:0]       dbg_d_i,
  input  logic                                dbg_stall_i,
  input  logic [dbg_unit_pkg::XLEN-1:0]       rf_q_i,
  input  logic [dbg_unit_pkg::XLEN-1:0]       csr_q_i,
  input  logic [dbg_unit_pkg::XLEN-1:0]       nxt_pc_i,
  output logic [dbg_unit_pkg::XLEN-1:0]       dbg_q_o,
  output logic                                dbg_ack_o,
  output logic                                we_rf_o,
  output logic                                re_rf_o,
  output logic                                we_csr_o,
  output logic                                re_csr_o,
  output logic                                we_pc_o,
  output logic [dbg_unit_pkg::DU_ADDR_W-1:0]  cpu_addr_o,
  output logic [dbg_unit_pkg::XLEN-1:0]       cpu_d_o,
  dbg_reg_if.host                             regs_o
);
  import dbg_unit_pkg::*;

  logic [BANK_W-1:0]    bank;
  logic [DU_ADDR_W-1:0] offset;
  logic                 sel_int;
  logic                 sel_gpr;
  logic                 sel_npc;
  logic                 sel_csr;
  logic                 access;
  logic                 wr;
  logic                 strb_q;
  logic                 we_int_q;
  logic [2:0]           ack_q;
  logic [DU_ADDR_W-1:0] addr_q;
  logic [XLEN-1:0]      data_q;

  //////////////////////////////////////////////////////////////////////
  // Address decode
  assign bank    = dbg_addr_i[DBG_ADDR_W-1:DU_ADDR_W];
  assign offset  = dbg_addr_i[DU_ADDR_W-1:0];
  assign sel_int = bank == BANK_INTERNAL;
  assign sel_gpr = (bank == BANK_GPRS) && (offset[11:8] == GPR_BASE[11:8]);
  assign sel_npc = (bank == BANK_GPRS) && (offset == NPC_OFFSET);
  assign sel_csr = bank == BANK_CSRS;

  // CPU banks only while the CPU is held
  assign access = dbg_strb_i & (sel_int | dbg_stall_i);

  // First accepted cycle only
  assign wr = access & ~strb_q & dbg_we_i;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      strb_q   <= 1'b0;
      we_int_q <= 1'b0;
      we_rf_o  <= 1'b0;
      we_csr_o <= 1'b0;
      we_pc_o  <= 1'b0;
    end
    else
    begin
      strb_q   <= dbg_strb_i;
      we_int_q <= wr & sel_int;
      we_rf_o  <= wr & sel_gpr;
      we_csr_o <= wr & sel_csr;
      we_pc_o  <= wr & sel_npc;
    end
  end

  always_ff @(posedge clk_i)
  begin
    addr_q <= offset;
    data_q <= dbg_d_i;
  end

  assign cpu_addr_o   = addr_q;
  assign cpu_d_o      = data_q;
  assign regs_o.we    = we_int_q;
  assign regs_o.addr  = addr_q;
  assign regs_o.wdata = data_q;

  assign re_rf_o  = dbg_strb_i & sel_gpr;
  assign re_csr_o = dbg_strb_i & sel_csr;

  //////////////////////////////////////////////////////////////////////
  // Acknowledge after three edges, then drop for one
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      ack_q <= 3'b000;
    else
      ack_q <= {3{access & ~dbg_ack_o}} & {1'b1, ack_q[2:1]};
  end

  assign dbg_ack_o = ack_q[0];

  // Read data, sampled from the live address every cycle
  always_ff @(posedge clk_i)
  begin
    if (sel_int)
      dbg_q_o <= regs_o.rdata;
    else if (sel_gpr)
      dbg_q_o <= rf_q_i;
    else if (sel_npc)
      dbg_q_o <= nxt_pc_i;
    else if (sel_csr)
      dbg_q_o <= csr_q_i;
    else
      dbg_q_o <= '0;
  end

endmodule

`default_nettype wire

// ==== hdl/dbg_reg_if.sv ====
// Internal register bus from the host port to the unit's register blocks and breakpoints
`timescale 1ns/10ps
`default_nettype none

interface dbg_reg_if;
  import dbg_unit_pkg::*;

  // Single-cycle write strobe
  logic                 we;
  // Registered in-bank address and write data
  logic [DU_ADDR_W-1:0] addr;
  logic [XLEN-1:0]      wdata;
  // Internal read word
  logic [XLEN-1:0]      rdata;

  modport host (
    output we, addr, wdata,
    input  rdata
  );

  modport regs (
    input  we, addr, wdata,
    output rdata
  );

  modport bp (
    input  we, addr, wdata
  );

endinterface

`default_nettype wire

// ==== hdl/dbg_unit_pkg.sv ====
// Shared widths, bank codes, register offsets and layouts for the debug unit; imported by its modules
`default_nettype none

package dbg_unit_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  localparam int unsigned XLEN       = 32;
  localparam int unsigned DBG_ADDR_W = 16;
  localparam int unsigned DU_ADDR_W  = 12;
  localparam int unsigned BANK_W     = 4;

  //////////////////////////////////////////////////////////////////////
  // Banks, selected by the upper address bits
  localparam logic [BANK_W-1:0] BANK_INTERNAL = 4'h0;
  localparam logic [BANK_W-1:0] BANK_GPRS     = 4'h1;
  localparam logic [BANK_W-1:0] BANK_CSRS     = 4'h2;

  // GPR bank, 32 integer registers where bits 11:8 are zero
  localparam logic [DU_ADDR_W-1:0] GPR_BASE   = 12'h000;
  localparam logic [DU_ADDR_W-1:0] NPC_OFFSET = 12'h200;

  //////////////////////////////////////////////////////////////////////
  // Internal registers
  localparam logic [DU_ADDR_W-1:0] REG_CTRL    = 12'h000;
  localparam logic [DU_ADDR_W-1:0] REG_HIT     = 12'h001;
  localparam logic [DU_ADDR_W-1:0] REG_IE      = 12'h002;
  localparam logic [DU_ADDR_W-1:0] REG_CAUSE   = 12'h003;
  // Breakpoint n sits at these plus 2*n
  localparam logic [DU_ADDR_W-1:0] REG_BPCTRL0 = 12'h010;
  localparam logic [DU_ADDR_W-1:0] REG_BPDATA0 = 12'h011;

  localparam int unsigned NUM_BP     = 3;
  localparam int unsigned HIT_BP_LSB = 4;

  //////////////////////////////////////////////////////////////////////
  // Breakpoint condition codes; any other code never hits
  localparam int unsigned CC_W = 3;

  localparam logic [CC_W-1:0] CC_FETCH = 3'd0;
  localparam logic [CC_W-1:0] CC_LOAD  = 3'd1;
  localparam logic [CC_W-1:0] CC_STORE = 3'd2;
  localparam logic [CC_W-1:0] CC_LDST  = 3'd3;

  // Breakpoint control word, register view bits 6:4, 1 and 0
  typedef struct packed {
    logic [CC_W-1:0] cc;
    logic            enabled;
    logic            implemented;
  } bp_ctrl_t;

  // Exception bits from here upward are interrupts
  localparam int unsigned IRQ_BASE = 16;

endpackage

`default_nettype wire
